// File: source/ooo_params.svh
/* Sizing macros for the out-of-order execution slice.
   Included by the package and by every module that sizes storage. */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Architectural and physical register counts
`define OOO_ARCH_REGS 32
`define OOO_PHYS_REGS 64

// Issue queue entries
`define OOO_IQ_DEPTH 8

// Cycles from multiply issue to result bus, at least 2
`define OOO_MUL_LAT 3

`endif

// File: source/ooo_pkg.sv
/* Shared types for the execution slice: register tags, data words and
   the operation and queue-slot encodings. */
`include "ooo_params.svh"

package ooo_pkg;

    // Architectural register number
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;

    // Physical register tag, tag 0 is the hardwired zero register
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_reg_t;

    // Instruction tag carried from dispatch to writeback
    typedef logic [5:0] rob_tag_t;

    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        MUL
    } alu_op_t;

    // Per-slot state of the issue queue
    typedef enum logic {
        EMPTY,
        WAITING
    } iq_state_t;

endpackage

// File: source/rename_stage.sv
/* Register alias table and circular free list. Renames each accepted
   instruction and takes back old tags announced on the result bus. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module rename_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  ooo_pkg::alu_op_t   in_op,
    input  ooo_pkg::arch_reg_t in_rd,
    input  ooo_pkg::arch_reg_t in_rs1,
    input  ooo_pkg::arch_reg_t in_rs2,
    input  logic               in_use_imm,
    input  ooo_pkg::word_t     in_imm,
    input  ooo_pkg::rob_tag_t  in_tag,
    input  logic               iq_full,
    input  logic               cdb_valid,
    input  ooo_pkg::phys_reg_t cdb_old_prd,
    output logic               stall,
    output logic               alloc_valid,
    output ooo_pkg::alu_op_t   alloc_op,
    output ooo_pkg::phys_reg_t alloc_prd,
    output ooo_pkg::phys_reg_t alloc_old_prd,
    output ooo_pkg::phys_reg_t alloc_prs1,
    output ooo_pkg::phys_reg_t alloc_prs2,
    output logic               alloc_use_imm,
    output ooo_pkg::word_t     alloc_imm,
    output ooo_pkg::rob_tag_t  alloc_tag
);

    localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    ooo_pkg::phys_reg_t  rat [`OOO_ARCH_REGS];
    ooo_pkg::phys_reg_t  free_list [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_PTR_W:0]   fl_count;
    logic                accept;
    logic                pop;
    logic                push;

    function automatic logic [FL_PTR_W-1:0] fl_next(input logic [FL_PTR_W-1:0] ptr);
        return (ptr == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign stall  = (fl_count == '0) || iq_full;
    assign accept = in_valid && !stall;
    // x0 keeps tag 0 and takes nothing from the free list
    assign pop    = accept && (in_rd != '0);
    assign push   = cdb_valid;

    assign alloc_valid   = accept;
    assign alloc_op      = in_op;
    assign alloc_prd     = (in_rd != '0) ? free_list[fl_head] : '0;
    assign alloc_old_prd = rat[in_rd];
    assign alloc_prs1    = rat[in_rs1];
    assign alloc_prs2    = rat[in_rs2];
    assign alloc_use_imm = in_use_imm;
    assign alloc_imm     = in_imm;
    assign alloc_tag     = in_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, upper half of the tags starts free
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                rat[i] <= ooo_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= ooo_pkg::phys_reg_t'(`OOO_ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_PTR_W + 1)'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat[in_rd] <= free_list[fl_head];
                fl_head    <= fl_next(fl_head);
            end
            if (push) begin
                free_list[fl_tail] <= cdb_old_prd;
                fl_tail            <= fl_next(fl_tail);
            end
            fl_count <= fl_count + (FL_PTR_W + 1)'(push) - (FL_PTR_W + 1)'(pop);
        end
    end

endmodule

// File: source/issue_queue.sv
/* In-order issue queue. The head leaves once its sources are ready and
   its result-bus slot is not claimed by a multiply in flight. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_queue (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  ooo_pkg::alu_op_t   alloc_op,
    input  ooo_pkg::phys_reg_t alloc_prd,
    input  ooo_pkg::phys_reg_t alloc_old_prd,
    input  ooo_pkg::phys_reg_t alloc_prs1,
    input  ooo_pkg::phys_reg_t alloc_prs2,
    input  logic               alloc_use_imm,
    input  ooo_pkg::word_t     alloc_imm,
    input  ooo_pkg::rob_tag_t  alloc_tag,
    input  ooo_pkg::word_t     rd_val1,
    input  logic               rd_busy1,
    input  ooo_pkg::word_t     rd_val2,
    input  logic               rd_busy2,
    output logic               iq_full,
    output ooo_pkg::phys_reg_t rd_prs1,
    output ooo_pkg::phys_reg_t rd_prs2,
    output logic               iss_valid,
    output ooo_pkg::alu_op_t   iss_op,
    output ooo_pkg::word_t     iss_a,
    output ooo_pkg::word_t     iss_b,
    output ooo_pkg::phys_reg_t iss_prd,
    output ooo_pkg::phys_reg_t iss_old_prd,
    output ooo_pkg::rob_tag_t  iss_tag
);

    localparam int DEPTH = `OOO_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LAT   = `OOO_MUL_LAT;

    ooo_pkg::iq_state_t state [DEPTH];
    ooo_pkg::alu_op_t   q_op [DEPTH];
    ooo_pkg::phys_reg_t q_prd [DEPTH];
    ooo_pkg::phys_reg_t q_old_prd [DEPTH];
    ooo_pkg::phys_reg_t q_prs1 [DEPTH];
    ooo_pkg::phys_reg_t q_prs2 [DEPTH];
    logic               q_use_imm [DEPTH];
    ooo_pkg::word_t     q_imm [DEPTH];
    ooo_pkg::rob_tag_t  q_tag [DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    // Bit i set means a multiply issued i+1 cycles ago
    logic [LAT-2:0]     mul_busy;
    logic               head_valid;
    logic               src_ready;
    logic               head_is_mul;
    logic               slot_free;
    logic               issue;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid  = (state[head] == ooo_pkg::WAITING);
    assign iq_full     = (state[tail] == ooo_pkg::WAITING);
    assign rd_prs1     = q_prs1[head];
    assign rd_prs2     = q_prs2[head];
    // Immediate forms do not wait on rs2
    assign src_ready   = !rd_busy1 && (q_use_imm[head] || !rd_busy2);
    assign head_is_mul = (q_op[head] == ooo_pkg::MUL);
    // ALU result would land together with the oldest multiply in flight
    assign slot_free   = head_is_mul || !mul_busy[LAT-2];
    assign issue       = head_valid && src_ready && slot_free;

    assign iss_valid   = issue;
    assign iss_op      = q_op[head];
    assign iss_a       = rd_val1;
    assign iss_b       = q_use_imm[head] ? q_imm[head] : rd_val2;
    assign iss_prd     = q_prd[head];
    assign iss_old_prd = q_old_prd[head];
    assign iss_tag     = q_tag[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= ooo_pkg::EMPTY;
            end
            head     <= '0;
            tail     <= '0;
            mul_busy <= '0;
        end else begin
            if (alloc_valid) begin
                state[tail] <= ooo_pkg::WAITING;
                tail        <= ptr_next(tail);
            end
            if (issue) begin
                state[head] <= ooo_pkg::EMPTY;
                head        <= ptr_next(head);
            end
            mul_busy[0] <= issue && head_is_mul;
            for (int i = 1; i < LAT - 1; i++) begin
                mul_busy[i] <= mul_busy[i-1];
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            q_op[tail]      <= alloc_op;
            q_prd[tail]     <= alloc_prd;
            q_old_prd[tail] <= alloc_old_prd;
            q_prs1[tail]    <= alloc_prs1;
            q_prs2[tail]    <= alloc_prs2;
            q_use_imm[tail] <= alloc_use_imm;
            q_imm[tail]     <= alloc_imm;
            q_tag[tail]     <= alloc_tag;
        end
    end

endmodule

// File: source/phys_reg_file.sv
/* Physical register values and busy bits. Reads are combinational and
   see a result-bus write in the same cycle. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module phys_reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  ooo_pkg::phys_reg_t alloc_prd,
    input  ooo_pkg::phys_reg_t rd_prs1,
    input  ooo_pkg::phys_reg_t rd_prs2,
    input  logic               cdb_valid,
    input  ooo_pkg::phys_reg_t cdb_prd,
    input  ooo_pkg::word_t     cdb_value,
    output ooo_pkg::word_t     rd_val1,
    output logic               rd_busy1,
    output ooo_pkg::word_t     rd_val2,
    output logic               rd_busy2
);

    ooo_pkg::word_t             value [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0]  busy;

    // Bus hit wins over storage, tag 0 is always zero
    function automatic ooo_pkg::word_t read_val(input ooo_pkg::phys_reg_t tag);
        if (tag == '0)
            return '0;
        if (cdb_valid && (cdb_prd == tag))
            return cdb_value;
        return value[tag];
    endfunction

    function automatic logic read_busy(input ooo_pkg::phys_reg_t tag);
        if ((tag == '0) || (cdb_valid && (cdb_prd == tag)))
            return 1'b0;
        return busy[tag];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                value[i] <= '0;
            end
            busy <= '0;
        end else begin
            // New producer marks its tag pending
            if (alloc_valid && (alloc_prd != '0))
                busy[alloc_prd] <= 1'b1;
            if (cdb_valid && (cdb_prd != '0)) begin
                value[cdb_prd] <= cdb_value;
                busy[cdb_prd]  <= 1'b0;
            end
        end
    end

    assign rd_val1  = read_val(rd_prs1);
    assign rd_busy1 = read_busy(rd_prs1);
    assign rd_val2  = read_val(rd_prs2);
    assign rd_busy2 = read_busy(rd_prs2);

endmodule

// File: source/exec_stage.sv
/* Execution units: a one-cycle ALU and a pipelined multiplier that share
   one result bus. Ops without a destination register write nothing back. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module exec_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               iss_valid,
    input  ooo_pkg::alu_op_t   iss_op,
    input  ooo_pkg::word_t     iss_a,
    input  ooo_pkg::word_t     iss_b,
    input  ooo_pkg::phys_reg_t iss_prd,
    input  ooo_pkg::phys_reg_t iss_old_prd,
    input  ooo_pkg::rob_tag_t  iss_tag,
    output logic               cdb_valid,
    output ooo_pkg::phys_reg_t cdb_prd,
    output ooo_pkg::phys_reg_t cdb_old_prd,
    output ooo_pkg::word_t     cdb_value,
    output ooo_pkg::rob_tag_t  cdb_tag
);

    localparam int LAT = `OOO_MUL_LAT;

    ooo_pkg::word_t     alu_result;
    logic               is_mul;
    logic               has_dest;
    logic               alu_valid;
    ooo_pkg::phys_reg_t alu_prd;
    ooo_pkg::phys_reg_t alu_old_prd;
    ooo_pkg::word_t     alu_value;
    ooo_pkg::rob_tag_t  alu_tag;
    logic               mul_valid [LAT];
    ooo_pkg::phys_reg_t mul_prd [LAT];
    ooo_pkg::phys_reg_t mul_old_prd [LAT];
    ooo_pkg::word_t     mul_value [LAT];
    ooo_pkg::rob_tag_t  mul_tag [LAT];

    assign is_mul   = (iss_op == ooo_pkg::MUL);
    assign has_dest = (iss_prd != '0);

    always_comb begin
        case (iss_op)
            ooo_pkg::ADD: alu_result = iss_a + iss_b;
            ooo_pkg::SUB: alu_result = iss_a - iss_b;
            ooo_pkg::AND: alu_result = iss_a & iss_b;
            ooo_pkg::OR:  alu_result = iss_a | iss_b;
            ooo_pkg::XOR: alu_result = iss_a ^ iss_b;
            default:      alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            for (int i = 0; i < LAT; i++) begin
                mul_valid[i] <= 1'b0;
            end
        end else begin
            alu_valid    <= iss_valid && !is_mul && has_dest;
            mul_valid[0] <= iss_valid && is_mul && has_dest;
            for (int i = 1; i < LAT; i++) begin
                mul_valid[i] <= mul_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        alu_prd     <= iss_prd;
        alu_old_prd <= iss_old_prd;
        alu_value   <= alu_result;
        alu_tag     <= iss_tag;
        // Low 32 bits of the product, then carried down the pipe
        mul_prd[0]     <= iss_prd;
        mul_old_prd[0] <= iss_old_prd;
        mul_value[0]   <= iss_a * iss_b;
        mul_tag[0]     <= iss_tag;
        for (int i = 1; i < LAT; i++) begin
            mul_prd[i]     <= mul_prd[i-1];
            mul_old_prd[i] <= mul_old_prd[i-1];
            mul_value[i]   <= mul_value[i-1];
            mul_tag[i]     <= mul_tag[i-1];
        end
    end

    // Issue logic keeps the two sources from colliding
    assign cdb_valid   = alu_valid || mul_valid[LAT-1];
    assign cdb_prd     = mul_valid[LAT-1] ? mul_prd[LAT-1] : alu_prd;
    assign cdb_old_prd = mul_valid[LAT-1] ? mul_old_prd[LAT-1] : alu_old_prd;
    assign cdb_value   = mul_valid[LAT-1] ? mul_value[LAT-1] : alu_value;
    assign cdb_tag     = mul_valid[LAT-1] ? mul_tag[LAT-1] : alu_tag;

endmodule

// File: source/ooo_slice_top.sv
/* Top of the execution slice: rename, issue queue, register file and
   execution units joined by the dispatch, read and result-bus wires. */
`timescale 1ns/1ps

module ooo_slice_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  ooo_pkg::alu_op_t   in_op,
    input  ooo_pkg::arch_reg_t in_rd,
    input  ooo_pkg::arch_reg_t in_rs1,
    input  ooo_pkg::arch_reg_t in_rs2,
    input  logic               in_use_imm,
    input  ooo_pkg::word_t     in_imm,
    input  ooo_pkg::rob_tag_t  in_tag,
    output logic               stall,
    output logic               wb_valid,
    output ooo_pkg::word_t     wb_value,
    output ooo_pkg::rob_tag_t  wb_tag
);

    // Rename to queue and register file
    logic               alloc_valid;
    ooo_pkg::alu_op_t   alloc_op;
    ooo_pkg::phys_reg_t alloc_prd;
    ooo_pkg::phys_reg_t alloc_old_prd;
    ooo_pkg::phys_reg_t alloc_prs1;
    ooo_pkg::phys_reg_t alloc_prs2;
    logic               alloc_use_imm;
    ooo_pkg::word_t     alloc_imm;
    ooo_pkg::rob_tag_t  alloc_tag;
    logic               iq_full;

    // Operand reads
    ooo_pkg::phys_reg_t rd_prs1;
    ooo_pkg::phys_reg_t rd_prs2;
    ooo_pkg::word_t     rd_val1;
    ooo_pkg::word_t     rd_val2;
    logic               rd_busy1;
    logic               rd_busy2;

    // Issue to execution
    logic               iss_valid;
    ooo_pkg::alu_op_t   iss_op;
    ooo_pkg::word_t     iss_a;
    ooo_pkg::word_t     iss_b;
    ooo_pkg::phys_reg_t iss_prd;
    ooo_pkg::phys_reg_t iss_old_prd;
    ooo_pkg::rob_tag_t  iss_tag;

    // Result bus
    logic               cdb_valid;
    ooo_pkg::phys_reg_t cdb_prd;
    ooo_pkg::phys_reg_t cdb_old_prd;
    ooo_pkg::word_t     cdb_value;
    ooo_pkg::rob_tag_t  cdb_tag;

    rename_stage u_rename (.*);

    issue_queue u_iq (.*);

    phys_reg_file u_prf (.*);

    exec_stage u_exec (.*);

    assign wb_valid = cdb_valid;
    assign wb_value = cdb_value;
    assign wb_tag   = cdb_tag;

endmodule

// File: tests/ooo_slice_assert.sv
/* Protocol and ordering assertions for the execution slice,
   bound into the slice top level. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_slice_assert (
    input logic               clk,
    input logic               rst,
    input logic               stall,
    input logic               alloc_valid,
    input ooo_pkg::phys_reg_t alloc_prd,
    input logic               iss_valid,
    input ooo_pkg::alu_op_t   iss_op,
    input logic               cdb_valid,
    input logic               wb_valid
);

    localparam int FREE_TAGS = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int IQ_DEPTH  = `OOO_IQ_DEPTH;

    int unsigned failures = 0;
    int          free_count;
    int          iq_count;

    // Shadow occupancy of the free list and the issue queue
    always_ff @(posedge clk) begin
        if (rst) begin
            free_count <= FREE_TAGS;
            iq_count   <= 0;
        end else begin
            free_count <= free_count + (cdb_valid ? 1 : 0)
                          - ((alloc_valid && (alloc_prd != '0)) ? 1 : 0);
            iq_count   <= iq_count + (alloc_valid ? 1 : 0) - (iss_valid ? 1 : 0);
        end
    end

    // A full queue must hold off dispatch
    stall_when_full: assert property (@(posedge clk) disable iff (rst)
        (iq_count == IQ_DEPTH) |-> stall)
        else begin
            failures++;
            $error("Issue queue full while stall was low");
        end

    // ALU result must not land on the cycle of a completing multiply
    bus_slot_free: assert property (@(posedge clk) disable iff (rst)
        (iss_valid && (iss_op != ooo_pkg::MUL))
            |-> !$past(iss_valid && (iss_op == ooo_pkg::MUL), `OOO_MUL_LAT - 1))
        else begin
            failures++;
            $error("ALU issued into a result-bus slot held by a multiply");
        end

    wb_quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_valid)
        else begin
            failures++;
            $error("Writeback valid in the cycle after reset");
        end

    free_list_bound: assert property (@(posedge clk) disable iff (rst)
        free_count <= FREE_TAGS)
        else begin
            failures++;
            $error("Free list holds more tags than it has entries");
        end

endmodule

bind ooo_slice_top ooo_slice_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .alloc_valid (alloc_valid),
    .alloc_prd   (alloc_prd),
    .iss_valid   (iss_valid),
    .iss_op      (iss_op),
    .cdb_valid   (cdb_valid),
    .wb_valid    (wb_valid)
);

// File: tests/ooo_slice_tb.sv
/* Testbench for the execution slice: directed and random instruction
   streams, checked by tag against an architectural reference model. */
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_slice_tb;

    localparam int TIMEOUT = 500;

    logic               clk;
    logic               rst;
    logic               in_valid;
    ooo_pkg::alu_op_t   in_op;
    ooo_pkg::arch_reg_t in_rd;
    ooo_pkg::arch_reg_t in_rs1;
    ooo_pkg::arch_reg_t in_rs2;
    logic               in_use_imm;
    ooo_pkg::word_t     in_imm;
    ooo_pkg::rob_tag_t  in_tag;
    logic               stall;
    logic               wb_valid;
    ooo_pkg::word_t     wb_value;
    ooo_pkg::rob_tag_t  wb_tag;

    // Reference state, results kept by tag until their writeback
    ooo_pkg::word_t     arch_regs [`OOO_ARCH_REGS];
    ooo_pkg::word_t     expected [64];
    logic               outstanding [64];
    // Writeback order, indexed by tag
    int                 wb_seq [64];
    int                 wb_count;
    ooo_pkg::rob_tag_t  next_tag;
    ooo_pkg::rob_tag_t  mul_tag;
    int                 pending;
    int                 stall_cycles;
    int                 value_errors;
    int                 tag_errors;
    int                 other_errors;
    int                 seed;
    string              test_name;
    logic               tag_known;

    ooo_slice_top dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_use_imm (in_use_imm),
        .in_imm     (in_imm),
        .in_tag     (in_tag),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_value   (wb_value),
        .wb_tag     (wb_tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic ooo_pkg::word_t ref_result(input ooo_pkg::alu_op_t op,
                                                  input ooo_pkg::word_t a,
                                                  input ooo_pkg::word_t b);
        case (op)
            ooo_pkg::ADD: return a + b;
            ooo_pkg::SUB: return a - b;
            ooo_pkg::AND: return a & b;
            ooo_pkg::OR:  return a | b;
            ooo_pkg::XOR: return a ^ b;
            ooo_pkg::MUL: return a * b;
            default:      return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input ooo_pkg::word_t exp,
                              input ooo_pkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_tag(input string name, input ooo_pkg::rob_tag_t tag,
                             output logic known);
        known = outstanding[tag];
        if (!known) begin
            $display("%s: writeback with tag %0d that was not outstanding", name, tag);
            tag_errors++;
        end
    endtask

    task automatic finish_run;
        int total;
        total = value_errors + tag_errors + other_errors + dut.u_assert.failures;
        $display("Errors: value %0d, tag %0d, other %0d, assertion %0d",
                 value_errors, tag_errors, other_errors, dut.u_assert.failures);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Holds the instruction until the edge that accepts it
    task automatic send(input ooo_pkg::alu_op_t op, input ooo_pkg::arch_reg_t rd,
                        input ooo_pkg::arch_reg_t rs1, input ooo_pkg::arch_reg_t rs2,
                        input logic use_imm, input ooo_pkg::word_t imm);
        ooo_pkg::word_t result;
        logic           stalled;
        int             waited;
        in_valid   <= 1'b1;
        in_op      <= op;
        in_rd      <= rd;
        in_rs1     <= rs1;
        in_rs2     <= rs2;
        in_use_imm <= use_imm;
        in_imm     <= imm;
        in_tag     <= next_tag;
        waited  = 0;
        stalled = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = stall;
            @(posedge clk);
            waited++;
            if (stalled) begin
                stall_cycles++;
            end
            if (stalled && (waited > TIMEOUT)) begin
                $display("Dispatch stalled for %0d cycles in %s", waited, test_name);
                other_errors++;
                in_valid <= 1'b0;
                return;
            end
        end
        result = ref_result(op, arch_regs[rs1], use_imm ? imm : arch_regs[rs2]);
        if (rd != '0) begin
            arch_regs[rd]       = result;
            expected[next_tag]  = result;
            outstanding[next_tag] = 1'b1;
            pending++;
        end
        next_tag = next_tag + 6'd1;
    endtask

    task automatic idle(input int cycles);
        in_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while ((pending != 0) && (waited < TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("%0d writebacks still missing at the end of %s", pending, test_name);
            other_errors++;
        end
    endtask

    task automatic random_stream(input int count);
        int             kind;
        logic [2:0]     op_code;
        ooo_pkg::word_t imm;
        for (int n = 0; n < count; n++) begin
            kind    = $random(seed);
            imm     = $random(seed);
            op_code = 3'(kind[7:0] % 8'd6);
            // Registers 0 to 15 only, so operands depend on recent results
            send(ooo_pkg::alu_op_t'(op_code), 5'(kind[16:13]), 5'(kind[12:9]),
                 5'(kind[24:21]), kind[8], imm);
            if (kind[31:28] == 4'd0) begin
                idle(1);
            end
        end
    endtask

    // Compare each writeback with the value stored under its tag
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            check_tag(test_name, wb_tag, tag_known);
            if (tag_known) begin
                check_word($sformatf("%s tag %0d", test_name, wb_tag),
                           expected[wb_tag], wb_value);
                outstanding[wb_tag] = 1'b0;
                wb_seq[wb_tag]      = wb_count;
                wb_count++;
                pending--;
            end
        end
    end

    initial begin
        seed       = 32'hb006;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = ooo_pkg::ADD;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_use_imm = 1'b0;
        in_imm     = '0;
        in_tag     = '0;
        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            outstanding[i] = 1'b0;
            expected[i]    = '0;
            wb_seq[i]      = 0;
        end
        next_tag     = '0;
        mul_tag      = '0;
        wb_count     = 0;
        pending      = 0;
        stall_cycles = 0;
        value_errors = 0;
        tag_errors   = 0;
        other_errors = 0;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "alu_imm";
        send(ooo_pkg::ADD, 5'd1, 5'd0, 5'd0, 1'b1, 32'd100);
        send(ooo_pkg::SUB, 5'd2, 5'd0, 5'd0, 1'b1, 32'd7);
        send(ooo_pkg::OR,  5'd3, 5'd0, 5'd0, 1'b1, 32'h00f0_0f00);
        send(ooo_pkg::XOR, 5'd4, 5'd0, 5'd0, 1'b1, 32'hdead_beef);
        send(ooo_pkg::AND, 5'd5, 5'd4, 5'd0, 1'b1, 32'h0000_ffff);
        idle(1);
        drain;

        // Back-to-back consumers hit the bus bypass
        test_name = "dependent_chain";
        send(ooo_pkg::ADD, 5'd6, 5'd1, 5'd0, 1'b1, 32'd5);
        send(ooo_pkg::ADD, 5'd7, 5'd6, 5'd6, 1'b0, 32'd0);
        send(ooo_pkg::SUB, 5'd8, 5'd7, 5'd1, 1'b0, 32'd0);
        send(ooo_pkg::XOR, 5'd6, 5'd8, 5'd4, 1'b0, 32'd0);
        send(ooo_pkg::MUL, 5'd9, 5'd6, 5'd7, 1'b0, 32'd0);
        send(ooo_pkg::ADD, 5'd10, 5'd9, 5'd0, 1'b1, 32'd1);
        idle(1);
        drain;

        test_name = "mul_out_of_order";
        mul_tag   = next_tag;
        send(ooo_pkg::MUL, 5'd11, 5'd3, 5'd4, 1'b0, 32'd0);
        send(ooo_pkg::ADD, 5'd12, 5'd1, 5'd2, 1'b0, 32'd0);
        send(ooo_pkg::OR,  5'd13, 5'd5, 5'd3, 1'b0, 32'd0);
        send(ooo_pkg::MUL, 5'd14, 5'd11, 5'd1, 1'b0, 32'd0);
        send(ooo_pkg::SUB, 5'd15, 5'd4, 5'd2, 1'b0, 32'd0);
        idle(1);
        drain;
        // The independent ADD finishes ahead of the older multiply
        if (wb_seq[mul_tag] < wb_seq[mul_tag + 6'd1]) begin
            $display("Multiply in %s wrote back before the younger ADD", test_name);
            other_errors++;
        end

        test_name = "x0_writes";
        send(ooo_pkg::ADD, 5'd0, 5'd1, 5'd2, 1'b0, 32'd0);
        send(ooo_pkg::MUL, 5'd0, 5'd3, 5'd4, 1'b0, 32'd0);
        send(ooo_pkg::ADD, 5'd16, 5'd0, 5'd0, 1'b1, 32'h0000_1234);
        send(ooo_pkg::OR,  5'd17, 5'd0, 5'd5, 1'b0, 32'd0);
        idle(8);
        drain;

        test_name    = "random_stream";
        stall_cycles = 0;
        // Chained multiplies fill the queue and raise stall
        for (int i = 0; i < 12; i++) begin
            send(ooo_pkg::MUL, 5'd1, 5'd1, 5'd2, 1'b0, 32'd0);
        end
        random_stream(800);
        idle(1);
        drain;
        if (stall_cycles == 0) begin
            $display("Stall was never raised during the random stream");
            other_errors++;
        end

        // Any stray writeback shows up as an unknown tag here
        idle(20);
        finish_run;
    end

endmodule

// File: flist.f
+incdir+source
source/ooo_pkg.sv
source/rename_stage.sv
source/issue_queue.sv
source/phys_reg_file.sv
source/exec_stage.sv
source/ooo_slice_top.sv
tests/ooo_slice_assert.sv
tests/ooo_slice_tb.sv

// File: Makefile
SIM       = verilator
TOP       = ooo_slice_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
SIM_FLAGS = --binary --timing --assert -j 0
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
